// File: board_pkg.sv
`default_nettype none

package board_pkg;

    //----------------------------------------------------------------------
    // Widths

    localparam int w_mic   = 24;  // INMP441 word
    localparam int w_sound = 16;  // Audio output word
    localparam int w_digit = 6;   // Static seven-segment digits

    //----------------------------------------------------------------------
    // Sample words between the pipeline stages

    typedef struct packed {
        logic                      valid;  // One-cycle strobe
        logic signed [w_mic - 1:0] data;
    } mic_sample_t;

    typedef struct packed {
        logic                        valid;
        logic signed [w_sound - 1:0] data;
    } sound_sample_t;

    // Active-low hgfedcba byte per digit, digit 0 in the low byte
    typedef logic [w_digit - 1:0][7:0] seg_bus_t;

    //----------------------------------------------------------------------
    // Nibble to abcdefgh, decimal point off

    function automatic logic [7:0] hex_to_seg(input logic [3:0] nibble);
        logic [7:0] seg;
        case (nibble)
            4'h0:    seg = 8'b1111_1100;
            4'h1:    seg = 8'b0110_0000;
            4'h2:    seg = 8'b1101_1010;
            4'h3:    seg = 8'b1111_0010;
            4'h4:    seg = 8'b0110_0110;
            4'h5:    seg = 8'b1011_0110;
            4'h6:    seg = 8'b1011_1110;
            4'h7:    seg = 8'b1110_0000;
            4'h8:    seg = 8'b1111_1110;
            4'h9:    seg = 8'b1111_0110;
            4'ha:    seg = 8'b1110_1110;
            4'hb:    seg = 8'b0011_1110;
            4'hc:    seg = 8'b1001_1100;
            4'hd:    seg = 8'b0111_1010;
            4'he:    seg = 8'b1001_1110;
            default: seg = 8'b1000_1110;  // F
        endcase
        return seg;
    endfunction

endpackage

`default_nettype wire

// File: inmp441_mic_i2s_receiver.sv
`default_nettype none

module inmp441_mic_i2s_receiver
#(
    parameter int sck_div = 8
)
(
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    sd,
    output logic                   sck,
    output logic                   ws,
    output logic                   lr,
    output board_pkg::mic_sample_t sample
);

    import board_pkg::*;

    localparam int w_div = sck_div > 1 ? $clog2(sck_div) : 1;

    logic [w_div - 1:0] div_cnt;
    logic               sck_tick;
    logic               sck_rise;
    logic               sck_fall;
    logic [5:0]         bit_cnt;    // sck period within the 64-period frame
    logic               capture;
    logic [w_mic - 1:0] shift;
    logic               last_bit;
    logic               out_valid;

    //----------------------------------------------------------------------
    // Bit clock and word select

    assign sck_tick = (div_cnt == w_div'(sck_div - 1));
    assign sck_rise = sck_tick & ~sck;
    assign sck_fall = sck_tick & sck;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
        end
        else if (sck_tick)
        begin
            div_cnt <= '0;
            sck     <= ~sck;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Period count advances as sck falls, so ws moves with the falling edge
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            bit_cnt <= '0;
        else if (sck_fall)
            bit_cnt <= bit_cnt + 6'd1;
    end

    assign ws = bit_cnt[5];  // Low for the left slot
    assign lr = 1'b0;        // Mic answers in the left slot

    //----------------------------------------------------------------------
    // Deserializer

    // Period 0 is the I2S delay bit, periods 1 to 24 carry MSB first
    assign capture = sck_rise && (bit_cnt >= 6'd1) && (bit_cnt <= 6'd24);

    always_ff @(posedge clk)
    begin
        if (capture)
            shift <= {shift[w_mic - 2:0], sd};
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            last_bit  <= 1'b0;
            out_valid <= 1'b0;
        end
        else
        begin
            last_bit  <= sck_rise && (bit_cnt == 6'd24);
            out_valid <= last_bit;  // One clock after the 24th bit
        end
    end

    // Shift register stays still until the next left slot
    assign sample = '{valid: out_valid, data: shift};

    // At most one word per frame
    assert property (@(posedge clk) disable iff (rst) out_valid |=> !out_valid)
        else $error("mic sample strobe high on two cycles in a row");

endmodule

`default_nettype wire

// File: audio_gain_stage.sv
`default_nettype none

module audio_gain_stage
(
    input  wire                      clk,
    input  wire                      rst,
    input  wire board_pkg::mic_sample_t in_sample,
    input  wire  [2:0]               gain,
    input  wire                      peak_clear,
    output board_pkg::sound_sample_t out_sample,
    output logic [15:0]              peak,
    output logic [3:0]               gain_shown
);

    import board_pkg::*;

    logic signed [w_sound - 1:0] top;   // Upper bits of the mic word
    logic signed [w_mic - 1:0]   wide;  // Room for a shift by 7
    logic signed [w_sound - 1:0] sat;
    logic        [15:0]          mag;
    logic                        out_valid;
    logic signed [w_sound - 1:0] out_data;

    //----------------------------------------------------------------------
    // Shift and saturate

    always_comb
    begin
        top  = in_sample.data[w_mic - 1 -: w_sound];
        wide = top;               // Sign extends
        wide = wide <<< gain;

        if (wide > 24'sd32767)
            sat = 16'sh7fff;
        else if (wide < -24'sd32768)
            sat = 16'sh8000;
        else
            sat = wide[w_sound - 1:0];
    end

    // Magnitude, with -32768 folded onto 32767
    always_comb
    begin
        if (sat == 16'sh8000)
            mag = 16'h7fff;
        else if (sat < 0)
            mag = 16'(-sat);
        else
            mag = 16'(sat);
    end

    //----------------------------------------------------------------------
    // Output register and peak hold

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            out_valid  <= 1'b0;
            peak       <= '0;
            gain_shown <= '0;
        end
        else
        begin
            out_valid <= in_sample.valid;

            if (in_sample.valid)
                gain_shown <= {1'b0, gain};

            if (peak_clear)
                peak <= '0;                 // Held key keeps it at zero
            else if (in_sample.valid && (mag > peak))
                peak <= mag;
        end
    end

    always_ff @(posedge clk)
    begin
        if (in_sample.valid)
            out_data <= sat;
    end

    assign out_sample = '{valid: out_valid, data: out_data};

    // Peak never trails the word just sent out
    assert property (@(posedge clk) disable iff (rst)
        $past(in_sample.valid && !peak_clear) |-> peak >= $past(mag))
        else $error("peak fell below the magnitude of the last output");

endmodule

`default_nettype wire

// File: seven_seg_scanner.sv
`default_nettype none

module seven_seg_scanner
#(
    parameter int scan_div = 5000
)
(
    input  wire                              clk,
    input  wire                              rst,
    input  wire  [4 * board_pkg::w_digit - 1:0] nibbles,
    output logic [7:0]                       abcdefgh,
    output logic [board_pkg::w_digit - 1:0]  digit
);

    import board_pkg::*;

    localparam int w_div = scan_div > 1 ? $clog2(scan_div) : 1;

    logic [w_div - 1:0] div_cnt;
    logic               scan_tick;
    logic [3:0]         nibble;

    //----------------------------------------------------------------------
    // Digit rotation

    assign scan_tick = (div_cnt == w_div'(scan_div - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            digit   <= w_digit'(1);   // Start on digit 0
        end
        else if (scan_tick)
        begin
            div_cnt <= '0;
            digit   <= {digit[w_digit - 2:0], digit[w_digit - 1]};
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    //----------------------------------------------------------------------
    // Nibble select and segment encode

    always_comb
    begin
        nibble = '0;
        for (int i = 0; i < w_digit; i++)
        begin
            if (digit[i])
                nibble = nibble | nibbles[i * 4 +: 4];
        end
    end

    assign abcdefgh = hex_to_seg(nibble);

    // Exactly one digit driven at a time
    assert property (@(posedge clk) disable iff (rst) $onehot(digit))
        else $error("digit select is not one-hot");

endmodule

`default_nettype wire

// File: static_seg_latch.sv
`default_nettype none

module static_seg_latch
(
    input  wire                             clk,
    input  wire                             rst,
    input  wire  [7:0]                      abcdefgh,
    input  wire  [board_pkg::w_digit - 1:0] digit,
    output board_pkg::seg_bus_t             hex
);

    import board_pkg::*;

    logic [7:0] hgfedcba;

    // Board pins take segment a in bit 0
    always_comb
    begin
        for (int i = 0; i < 8; i++)
            hgfedcba[i] = abcdefgh[7 - i];
    end

    //----------------------------------------------------------------------
    // Sticky per-digit flops, so static digits stay fully lit

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            hex <= '1;  // All blank
        end
        else
        begin
            for (int i = 0; i < w_digit; i++)
            begin
                if (digit[i])
                    hex[i] <= ~hgfedcba;   // Active low
            end
        end
    end

endmodule

`default_nettype wire

// File: i2s_audio_out.sv
`default_nettype none

module i2s_audio_out
#(
    parameter int bclk_div = 8
)
(
    input  wire                          clk,
    input  wire                          rst,
    input  wire board_pkg::sound_sample_t in_sample,
    output logic                         bclk,
    output logic                         lrclk,
    output logic                         sdata
);

    import board_pkg::*;

    localparam int w_div = bclk_div > 1 ? $clog2(bclk_div) : 1;

    logic [w_div - 1:0]   div_cnt;
    logic                 bclk_tick;
    logic                 bclk_fall;
    logic [5:0]           bit_cnt;    // bclk period within the frame
    logic [5:0]           next_cnt;
    logic [w_sound - 1:0] held;       // Newest strobed sample
    logic [w_sound - 1:0] newest;
    logic [w_sound - 1:0] frame_word; // Word sent in both slots
    logic [w_sound - 1:0] shifter;

    //----------------------------------------------------------------------
    // Bit clock

    assign bclk_tick = (div_cnt == w_div'(bclk_div - 1));
    assign bclk_fall = bclk_tick & bclk;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            bclk    <= 1'b0;
        end
        else if (bclk_tick)
        begin
            div_cnt <= '0;
            bclk    <= ~bclk;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign next_cnt = bit_cnt + 6'd1;
    assign lrclk    = bit_cnt[5];   // Low for left

    //----------------------------------------------------------------------
    // Sample hold

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            held <= '0;
        else if (in_sample.valid)
            held <= in_sample.data;
    end

    // A strobe on the frame edge itself still makes it
    assign newest = in_sample.valid ? in_sample.data : held;

    //----------------------------------------------------------------------
    // Serializer, everything moves on the bclk fall

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            bit_cnt    <= '0;
            sdata      <= 1'b0;
            frame_word <= '0;
            shifter    <= '0;
        end
        else if (bclk_fall)
        begin
            bit_cnt <= next_cnt;

            if (next_cnt[4:0] == 5'd0)
            begin
                sdata <= 1'b0;            // Delay bit
                if (!next_cnt[5])
                begin
                    frame_word <= newest; // lrclk falls, new frame
                    shifter    <= newest;
                end
                else
                begin
                    shifter <= frame_word;
                end
            end
            else
            begin
                // Zeros follow once the word has shifted out
                sdata   <= shifter[w_sound - 1];
                shifter <= {shifter[w_sound - 2:0], 1'b0};
            end
        end
    end

    // Data line only moves together with a falling bclk
    assert property (@(posedge clk) disable iff (rst)
        $changed(sdata) |-> $past(bclk_fall))
        else $error("sdata changed away from a bclk fall");

endmodule

`default_nettype wire

// File: board_specific_top.sv
`default_nettype none

module board_specific_top
#(
    parameter int sck_div  = 8,
    parameter int bclk_div = 8,
    parameter int scan_div = 5000
)
(
    input  wire                 clk,
    input  wire                 rst,
    input  wire  [1:0]          key,       // Active low
    input  wire  [2:0]          sw,        // Gain
    input  wire                 mic_sd,
    output logic                mic_sck,
    output logic                mic_ws,
    output logic                mic_lr,
    output logic                aud_bclk,
    output logic                aud_lrclk,
    output logic                aud_sdata,
    output board_pkg::seg_bus_t hex
);

    import board_pkg::*;

    mic_sample_t              mic_sample;
    sound_sample_t            sound_sample;
    logic [15:0]              peak;
    logic [3:0]               gain_shown;
    logic                     peak_clear;
    logic [4 * w_digit - 1:0] nibbles;
    logic [7:0]               abcdefgh;
    logic [w_digit - 1:0]     digit;

    assign peak_clear = ~key[0];

    // Peak on digits 0 to 3, gain on 4, digit 5 shows zero
    assign nibbles = {4'h0, gain_shown, peak};

    //----------------------------------------------------------------------
    // Audio pipeline

    inmp441_mic_i2s_receiver #(.sck_div(sck_div)) i_microphone
    (
        .clk    ( clk        ),
        .rst    ( rst        ),
        .sd     ( mic_sd     ),
        .sck    ( mic_sck    ),
        .ws     ( mic_ws     ),
        .lr     ( mic_lr     ),
        .sample ( mic_sample )
    );

    audio_gain_stage i_gain
    (
        .clk        ( clk          ),
        .rst        ( rst          ),
        .in_sample  ( mic_sample   ),
        .gain       ( sw           ),
        .peak_clear ( peak_clear   ),
        .out_sample ( sound_sample ),
        .peak       ( peak         ),
        .gain_shown ( gain_shown   )
    );

    i2s_audio_out #(.bclk_div(bclk_div)) i_audio_out
    (
        .clk       ( clk          ),
        .rst       ( rst          ),
        .in_sample ( sound_sample ),
        .bclk      ( aud_bclk     ),
        .lrclk     ( aud_lrclk    ),
        .sdata     ( aud_sdata    )
    );

    //----------------------------------------------------------------------
    // Display branch

    seven_seg_scanner #(.scan_div(scan_div)) i_scanner
    (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .nibbles  ( nibbles  ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    )
    );

    static_seg_latch i_seg_latch
    (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    ),
        .hex      ( hex      )
    );

endmodule

`default_nettype wire

// File: tb_board_specific_top.sv
`default_nettype none

module tb_board_specific_top;

    import board_pkg::*;

    localparam int sck_div    = 2;
    localparam int bclk_div   = 2;
    localparam int scan_div   = 4;
    localparam int n_frames   = 40;
    localparam int max_cycles = (n_frames + 4) * 64 * 2 * bclk_div;

    logic       clk;
    logic       rst;
    logic [1:0] key;
    logic [2:0] sw;
    logic       mic_sd;
    logic       mic_sck;
    logic       mic_ws;
    logic       mic_lr;
    logic       aud_bclk;
    logic       aud_lrclk;
    logic       aud_sdata;
    seg_bus_t   hex;

    integer                      seed;
    logic [w_mic - 1:0]          mic_word;     // Word being sent by the mic model
    logic [5:0]                  mic_cnt;      // sck period within the mic frame
    logic [5:0]                  aud_cnt;      // bclk period within the audio frame
    logic                        sck_prev;
    logic                        bclk_prev;
    logic signed [w_sound - 1:0] exp_hist[$];  // Expected output of recent samples
    logic [15:0]                 model_peak;
    logic [3:0]                  model_gain;
    logic [w_sound - 1:0]        left_word;
    logic [w_sound - 1:0]        right_word;
    int                          mic_frames;
    int                          frames_done;
    int                          cycles;
    int                          since_sck;
    int                          since_bclk;

    board_specific_top #(.sck_div(sck_div), .bclk_div(bclk_div), .scan_div(scan_div)) dut0
    (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .key       ( key       ),
        .sw        ( sw        ),
        .mic_sd    ( mic_sd    ),
        .mic_sck   ( mic_sck   ),
        .mic_ws    ( mic_ws    ),
        .mic_lr    ( mic_lr    ),
        .aud_bclk  ( aud_bclk  ),
        .aud_lrclk ( aud_lrclk ),
        .aud_sdata ( aud_sdata ),
        .hex       ( hex       )
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    //----------------------------------------------------------------------
    // Reference model

    // Top 16 bits, shifted by the gain, clipped to full scale
    function automatic logic signed [w_sound - 1:0] expected_word(input logic [w_mic - 1:0] word,
                                                                  input logic [2:0] gain);
        int v;
        v = int'($signed(word[w_mic - 1 -: w_sound])) * (1 << gain);
        if (v > 32767)
            v = 32767;
        else if (v < -32768)
            v = -32768;
        return w_sound'(v);
    endfunction

    function automatic logic [15:0] magnitude(input logic signed [w_sound - 1:0] s);
        int v;
        v = s;
        if (v < 0)
            v = -v;
        if (v > 32767)
            v = 32767;   // Full negative scale caps here
        return 16'(v);
    endfunction

    // Pin byte is hgfedcba, active low
    function automatic logic [7:0] pin_byte(input logic [3:0] nibble);
        logic [7:0] seg;
        logic [7:0] rev;
        seg = hex_to_seg(nibble);
        for (int i = 0; i < 8; i++)
            rev[i] = seg[7 - i];
        return ~rev;
    endfunction

    function automatic seg_bus_t expected_hex(input logic [15:0] peak, input logic [3:0] gain);
        seg_bus_t e;
        for (int i = 0; i < 4; i++)
            e[i] = pin_byte(peak[i * 4 +: 4]);
        e[4] = pin_byte(gain);
        e[5] = pin_byte(4'h0);
        return e;
    endfunction

    //----------------------------------------------------------------------
    // Checks

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic check_sound(input logic signed [w_sound - 1:0] got,
                               input logic [1:0][w_sound - 1:0] expected, input string what);
        if (got !== expected[0] && got !== expected[1])
            abort_run($sformatf("MISMATCH at %0t: %s word %h, expected %h or %h",
                                $time, what, got, expected[0], expected[1]));
    endtask

    task automatic check_hex(input seg_bus_t got, input seg_bus_t expected);
        if (got !== expected)
            abort_run($sformatf("MISMATCH at %0t: hex %h, expected %h", $time, got, expected));
    endtask

    task automatic check_level(input logic got, input logic expected, input string what);
        if (got !== expected)
            abort_run($sformatf("MISMATCH at %0t: %s is %b, expected %b",
                                $time, what, got, expected));
    endtask

    //----------------------------------------------------------------------
    // Microphone model, runs 1 unit after each rising clk

    task mic_step;
        logic [15:0] mag;
        since_sck++;
        if (sck_prev && !mic_sck)
        begin
            since_sck = 0;
            mic_cnt++;
            check_level(mic_ws, mic_cnt[5], "mic_ws");
            if (mic_cnt == 6'd1)
            begin
                mic_word = w_mic'($random(seed));
                mic_frames++;
            end
            // Delay bit at period 0, then MSB first
            if (mic_cnt >= 6'd1 && mic_cnt <= 6'd24)
                mic_sd = mic_word[w_mic - int'(mic_cnt)];
            else
                mic_sd = 1'b0;

            if (mic_cnt == 6'd25)   // Gain stage took the word on this edge
            begin
                exp_hist.push_back(expected_word(mic_word, sw));
                if (exp_hist.size() > 2)
                    exp_hist.pop_front();
                model_gain = {1'b0, sw};
                mag = magnitude(expected_word(mic_word, sw));
                if (key[0] && mag > model_peak)
                    model_peak = mag;
            end
            if (mic_cnt == 6'd40)   // Display long settled by now
                check_hex(hex, expected_hex(model_peak, model_gain));
            if (mic_cnt == 6'd41)
            begin
                sw = (mic_frames < 6) ? 3'd0 : 3'($random(seed));
                if (mic_frames % 9 == 5)
                begin
                    key        = 2'b10;   // Hold peak clear
                    model_peak = '0;
                end
            end
            if (mic_cnt == 6'd50)
                key = 2'b11;
        end
        sck_prev = mic_sck;
        if (since_sck > 4 * sck_div)
            abort_run("Microphone bit clock stopped toggling");
    endtask

    //----------------------------------------------------------------------
    // I2S output decoder

    task audio_step;
        logic [1:0][w_sound - 1:0] exp_set;
        since_bclk++;
        if (bclk_prev && !aud_bclk)
        begin
            since_bclk = 0;
            aud_cnt++;
            check_level(aud_lrclk, aud_cnt[5], "aud_lrclk");
        end
        if (!bclk_prev && aud_bclk)
        begin
            since_bclk = 0;
            if (aud_cnt >= 6'd1 && aud_cnt <= 6'd16)
                left_word = {left_word[w_sound - 2:0], aud_sdata};
            else if (aud_cnt >= 6'd33 && aud_cnt <= 6'd48)
                right_word = {right_word[w_sound - 2:0], aud_sdata};
            else
                check_level(aud_sdata, 1'b0, "aud_sdata padding");

            if (aud_cnt == 6'd48)
            begin
                exp_set = '0;   // Silence before the first word gets through
                if (exp_hist.size() > 0)
                    exp_set[1] = exp_hist[exp_hist.size() - 1];
                if (exp_hist.size() > 1)
                    exp_set[0] = exp_hist[exp_hist.size() - 2];
                check_sound(left_word, exp_set, "left");
                check_sound(right_word, {left_word, left_word}, "right");
                frames_done++;
            end
        end
        bclk_prev = aud_bclk;
        if (since_bclk > 4 * bclk_div)
            abort_run("Audio bit clock stopped toggling");
    endtask

    //----------------------------------------------------------------------
    // Stimulus

    initial
    begin
        seed        = 32'h1ced_39fd;
        rst         = 1'b1;
        key         = 2'b11;
        sw          = 3'd0;
        mic_sd      = 1'b0;
        mic_word    = '0;
        mic_cnt     = '0;
        aud_cnt     = '0;
        sck_prev    = 1'b0;
        bclk_prev   = 1'b0;
        model_peak  = '0;
        model_gain  = '0;
        left_word   = '0;
        right_word  = '0;
        mic_frames  = 0;
        frames_done = 0;
        cycles      = 0;
        since_sck   = 0;
        since_bclk  = 0;

        repeat (10) @(posedge clk);
        #1;
        check_hex(hex, '1);
        check_level(mic_sck, 1'b0, "mic_sck");
        check_level(mic_lr, 1'b0, "mic_lr");
        check_level(aud_bclk, 1'b0, "aud_bclk");
        check_level(aud_sdata, 1'b0, "aud_sdata");
        rst = 1'b0;

        while (frames_done < n_frames)
        begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > max_cycles)
                abort_run("Timeout waiting for decoded audio frames");
            mic_step();
            audio_step();
        end

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// File: board_specific_top.f
board_pkg.sv
inmp441_mic_i2s_receiver.sv
audio_gain_stage.sv
seven_seg_scanner.sv
static_seg_latch.sv
i2s_audio_out.sv
board_specific_top.sv
tb_board_specific_top.sv

// File: Bender.yml
package:
  name: board_specific_top

sources:
  - board_pkg.sv
  - inmp441_mic_i2s_receiver.sv
  - audio_gain_stage.sv
  - seven_seg_scanner.sv
  - static_seg_latch.sv
  - i2s_audio_out.sv
  - board_specific_top.sv
  - target: test
    files:
      - tb_board_specific_top.sv
